// ==== cache_ctrl_fsm.sv ====
// cache controller, sequences compare, write-back, allocate, commit and retry
`timescale 1ns/1ns
`include "mem_sys_defs.svh"

module cache_ctrl_fsm (
  input  logic                     clk,
  input  logic                     arst_n,
  input  logic                     req_valid,
  input  logic                     req_bad,
  input  logic                     req_is_wr,
  input  logic                     hit,
  input  logic                     dirty_victim,
  input  logic                     rvalid,
  input  logic                     mem_stall,
  output mem_sys_pkg::ctrl_state_t state,
  output logic                     stall,
  output logic                     done,
  output logic                     err,
  output logic                     way_comp,
  output logic                     way_write,
  output logic                     way_valid_in,
  output logic [`OFFS_W-2:0]       word_sel,
  output mem_sys_pkg::mem_op_t     mem_op,
  output logic [`OFFS_W-2:0]       mem_word
);

  mem_sys_pkg::ctrl_state_t state_nxt;
  mem_sys_pkg::ctrl_state_t start_st;  // where a newly accepted request goes
  logic [`OFFS_W-2:0]       seq_word;  // word of the current WB_*/ALLOC_* step
  logic [`OFFS_W-2:0]       inst_cnt;  // next word to install
  logic                     miss_wr;
  logic                     cmp_st;

  assign cmp_st = (state == mem_sys_pkg::COMPARE_RD) || (state == mem_sys_pkg::COMPARE_WR);
  assign done   = (cmp_st && hit) || (state == mem_sys_pkg::RETRY);
  assign err    = (state == mem_sys_pkg::ERR_STATE);
  assign stall  = !((state == mem_sys_pkg::IDLE) || err || done);

  always_comb begin
    if (req_valid) begin
      start_st = req_is_wr ? mem_sys_pkg::COMPARE_WR : mem_sys_pkg::COMPARE_RD;
    end else if (req_bad) begin
      start_st = mem_sys_pkg::ERR_STATE;
    end else begin
      start_st = mem_sys_pkg::IDLE;
    end
  end

  always_comb begin
    unique case (state)
      mem_sys_pkg::WB_1, mem_sys_pkg::ALLOC_1: seq_word = 2'd1;
      mem_sys_pkg::WB_2, mem_sys_pkg::ALLOC_2: seq_word = 2'd2;
      mem_sys_pkg::WB_3, mem_sys_pkg::ALLOC_3: seq_word = 2'd3;
      default:                                 seq_word = 2'd0;
    endcase
  end

  always_comb begin
    state_nxt    = state;
    way_comp     = 1'b0;
    way_write    = 1'b0;
    way_valid_in = 1'b0;
    word_sel     = inst_cnt;
    mem_op       = mem_sys_pkg::MEM_NOP;
    mem_word     = seq_word;
    unique case (state)
      mem_sys_pkg::IDLE, mem_sys_pkg::ERR_STATE: state_nxt = start_st;
      mem_sys_pkg::COMPARE_RD, mem_sys_pkg::COMPARE_WR: begin
        way_comp  = 1'b1;
        way_write = (state == mem_sys_pkg::COMPARE_WR);
        if (hit) begin
          state_nxt = start_st;
        end else if (dirty_victim) begin
          state_nxt = mem_sys_pkg::WB_0;
        end else begin
          state_nxt = mem_sys_pkg::ALLOC_0;
        end
      end
      mem_sys_pkg::WB_0, mem_sys_pkg::WB_1, mem_sys_pkg::WB_2, mem_sys_pkg::WB_3: begin
        word_sel = seq_word;  // victim word out to its bank
        mem_op   = mem_sys_pkg::MEM_WR;
        if (!mem_stall) begin
          state_nxt = mem_sys_pkg::ctrl_state_t'(state + 4'd1);  // WB_3 falls into ALLOC_0
        end
      end
      mem_sys_pkg::ALLOC_0, mem_sys_pkg::ALLOC_1,
      mem_sys_pkg::ALLOC_2, mem_sys_pkg::ALLOC_3: begin
        mem_op    = mem_sys_pkg::MEM_RD;
        way_write = rvalid;  // earlier reads land while later ones issue
        if (!mem_stall) begin
          state_nxt = mem_sys_pkg::ctrl_state_t'(state + 4'd1);
        end
      end
      mem_sys_pkg::INSTALL_WAIT: begin
        way_write = rvalid;
        if (rvalid && inst_cnt == '1) begin
          state_nxt = mem_sys_pkg::COMMIT;
        end
      end
      mem_sys_pkg::COMMIT: begin
        // rewrite last word, memory still holds it, and mark the line valid
        way_write    = 1'b1;
        way_valid_in = 1'b1;
        word_sel     = '1;
        state_nxt    = mem_sys_pkg::RETRY;
      end
      mem_sys_pkg::RETRY: begin
        way_comp  = 1'b1;
        way_write = miss_wr;  // write-allocate store
        state_nxt = start_st;
      end
      default: state_nxt = mem_sys_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state    <= mem_sys_pkg::IDLE;
      inst_cnt <= '0;
      miss_wr  <= 1'b0;
    end else begin
      state <= state_nxt;
      if (rvalid) begin
        inst_cnt <= inst_cnt + 1'b1;
      end
      if (cmp_st && !hit) begin
        miss_wr <= (state == mem_sys_pkg::COMPARE_WR);
      end
    end
  end

  a_bad_gives_err: assert property (@(posedge clk) disable iff (!arst_n)
    req_bad |=> err && !done);
  a_idle_no_stall: assert property (@(posedge clk) disable iff (!arst_n)
    state == mem_sys_pkg::IDLE |-> !stall);

endmodule

// ==== cache_way.sv ====
// one way of the two-way cache, tag, valid, dirty and four data words per set
`timescale 1ns/1ns
`include "mem_sys_defs.svh"

module cache_way (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                en,
  input  logic                comp,
  input  logic                write,
  input  logic                valid_in,
  input  logic [`TAG_W-1:0]   tag_in,
  input  logic [`INDEX_W-1:0] index,
  input  logic [`OFFS_W-2:0]  word,
  input  logic [`DATA_W-1:0]  wdata,
  output logic                hit,
  output logic                valid,
  output logic                dirty,
  output logic [`TAG_W-1:0]   tag_out,
  output logic [`DATA_W-1:0]  rdata
);

  localparam int SETS = 1 << `INDEX_W;

  logic [SETS-1:0]    valid_q;
  logic [SETS-1:0]    dirty_q;
  logic [`TAG_W-1:0]  tag_q  [SETS];
  logic [`DATA_W-1:0] data_q [SETS][`WORDS_PER_LINE];
  logic               tag_match;
  logic               cmp_wr;  // store into a matching line
  logic               acc_wr;  // install from memory

  assign tag_match = valid_q[index] && (tag_q[index] == tag_in);
  assign cmp_wr    = en && write && comp && tag_match;
  assign acc_wr    = en && write && !comp;

  assign hit     = en && comp && tag_match;
  assign valid   = valid_q[index];
  assign dirty   = dirty_q[index];
  assign tag_out = tag_q[index];
  assign rdata   = data_q[index][word];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      valid_q <= '0;
      dirty_q <= '0;
    end else if (acc_wr) begin
      valid_q[index] <= valid_in;  // line stays invalid until commit
      dirty_q[index] <= 1'b0;
    end else if (cmp_wr) begin
      dirty_q[index] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (acc_wr) begin
      tag_q[index] <= tag_in;
    end
    if (acc_wr || cmp_wr) begin
      data_q[index][word] <= wdata;
    end
  end

  // a disabled way keeps its line untouched
  a_no_write_when_off: assert property (@(posedge clk) disable iff (!arst_n)
    !en ##1 (index == $past(index) && word == $past(word))
    |-> $stable(tag_out) && $stable(valid) && $stable(dirty) && $stable(rdata));

endmodule

// ==== four_bank_mem.sv ====
// four-bank interleaved main memory with fixed read latency and per-bank busy time
`timescale 1ns/1ns
`include "mem_sys_defs.svh"

module four_bank_mem (
  input  logic                 clk,
  input  logic                 arst_n,
  input  mem_sys_pkg::mem_op_t mem_op,
  input  logic [`ADDR_W-1:0]   addr,
  input  logic [`DATA_W-1:0]   wdata,
  output logic [`DATA_W-1:0]   rdata,
  output logic                 rvalid,
  output logic                 mem_stall
);

  localparam int ROW_W = `ADDR_W - `OFFS_W;
  localparam int CNT_W = $clog2(`BANK_BUSY);

  logic [`DATA_W-1:0]    mem_q [`WORDS_PER_LINE][1 << ROW_W];
  logic [CNT_W-1:0]      busy_cnt [`WORDS_PER_LINE];
  logic [`OFFS_W-2:0]    bank;
  logic [ROW_W-1:0]      row;
  logic                  bank_busy;
  logic                  wr_acc;
  logic                  rd_acc;
  logic                  acc;
  logic [`MEM_RD_LAT-1:0] pipe_v;
  logic [`DATA_W-1:0]    pipe_d [`MEM_RD_LAT];

  assign bank      = addr[`OFFS_W-1:1];
  assign row       = addr[`ADDR_W-1:`OFFS_W];
  assign bank_busy = (busy_cnt[bank] != '0);
  assign mem_stall = (mem_op != mem_sys_pkg::MEM_NOP) && bank_busy;
  assign wr_acc    = (mem_op == mem_sys_pkg::MEM_WR) && !bank_busy;
  assign rd_acc    = (mem_op == mem_sys_pkg::MEM_RD) && !bank_busy;
  assign acc       = wr_acc || rd_acc;

  initial begin
    for (int b = 0; b < `WORDS_PER_LINE; b++) begin
      for (int r = 0; r < (1 << ROW_W); r++) begin
        mem_q[b][r] = '0;
      end
    end
  end

  always @(posedge clk) begin
    if (wr_acc) begin
      mem_q[bank][row] <= wdata;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int b = 0; b < `WORDS_PER_LINE; b++) begin
        busy_cnt[b] <= '0;
      end
      pipe_v <= '0;
    end else begin
      for (int b = 0; b < `WORDS_PER_LINE; b++) begin
        if (acc && bank == b) begin
          busy_cnt[b] <= CNT_W'(`BANK_BUSY - 1);
        end else if (busy_cnt[b] != '0) begin
          busy_cnt[b] <= busy_cnt[b] - 1'b1;
        end
      end
      pipe_v <= {pipe_v[`MEM_RD_LAT-2:0], rd_acc};
    end
  end

  // data moves only with its valid, so rdata holds the last returned word
  always_ff @(posedge clk) begin
    if (rd_acc) begin
      pipe_d[0] <= mem_q[bank][row];
    end
    for (int i = 1; i < `MEM_RD_LAT; i++) begin
      if (pipe_v[i-1]) begin
        pipe_d[i] <= pipe_d[i-1];
      end
    end
  end

  assign rvalid = pipe_v[`MEM_RD_LAT-1];
  assign rdata  = pipe_d[`MEM_RD_LAT-1];

  for (genvar b = 0; b < `WORDS_PER_LINE; b++) begin : g_bank_chk
    a_busy_gap: assert property (@(posedge clk) disable iff (!arst_n)
      (acc && bank == b) |=> (!(acc && bank == b)) [*(`BANK_BUSY-1)]);
  end

endmodule

// ==== mem_sys_defs.svh ====
// geometry and memory timing macros for the cache and banked memory, included by the RTL
`ifndef MEM_SYS_DEFS_SVH
`define MEM_SYS_DEFS_SVH

// request and word widths
`define ADDR_W 16
`define DATA_W 16

// address split is tag [15:11], index [10:3], offset [2:0]
`define TAG_W   5
`define INDEX_W 8
`define OFFS_W  3

// words per line, also the number of memory banks
// bank select is addr[2:1]
`define WORDS_PER_LINE 4

// main memory timing in cycles
`define MEM_RD_LAT 2  // read strobe to rvalid
`define BANK_BUSY  4  // bank blocked after any access

`endif

// ==== mem_sys_pkg.sv ====
// shared enums for the cache controller states and the main memory commands
package mem_sys_pkg;

  // controller states
  // WB_* and ALLOC_* stay consecutive, the fsm steps through them with +1
  typedef enum logic [3:0] {
    IDLE,
    COMPARE_RD,
    COMPARE_WR,
    WB_0, WB_1, WB_2, WB_3,
    ALLOC_0, ALLOC_1, ALLOC_2, ALLOC_3,
    INSTALL_WAIT,
    COMMIT,
    RETRY,
    ERR_STATE
  } ctrl_state_t;

  // command to the banked memory
  typedef enum logic [1:0] {
    MEM_NOP,
    MEM_RD,
    MEM_WR
  } mem_op_t;

endpackage

// ==== mem_system.sv ====
// top level of the cached memory system, two-way cache in front of banked memory
`timescale 1ns/1ns
`include "mem_sys_defs.svh"

module mem_system (
  input  logic               clk,
  input  logic               arst_n,
  input  logic [`ADDR_W-1:0] addr,
  input  logic [`DATA_W-1:0] data_in,
  input  logic               rd,
  input  logic               wr,
  output logic [`DATA_W-1:0] data_out,
  output logic               done,
  output logic               stall,
  output logic               cache_hit,
  output logic               err
);

  logic [`TAG_W-1:0]   req_tag, victim_tag, tag0, tag1;
  logic [`INDEX_W-1:0] req_index;
  logic [`OFFS_W-1:0]  req_offset;
  logic [`DATA_W-1:0]  req_wdata, line_data, rdata0, rdata1, mem_rdata, way_wdata;
  logic [`OFFS_W-2:0]  word_sel, mem_word, way_word;
  logic [`ADDR_W-1:0]  mem_addr;
  logic req_is_wr, req_valid, req_bad, way_comp, way_write, way_valid_in;
  logic en0, en1, hit0, hit1, valid0, valid1, dirty0, dirty1, hit, dirty_victim;
  logic rvalid, mem_stall;
  mem_sys_pkg::ctrl_state_t state;
  mem_sys_pkg::mem_op_t     mem_op;

  // compare uses the request word and data, fills use the sequencer and memory
  assign way_word  = way_comp ? req_offset[`OFFS_W-1:1] : word_sel;
  assign way_wdata = way_comp ? req_wdata : mem_rdata;
  // write-back goes to the victim's address
  assign mem_addr  = {(mem_op == mem_sys_pkg::MEM_WR) ? victim_tag : req_tag,
                      req_index, mem_word, 1'b0};
  assign data_out  = line_data;
  assign cache_hit = hit && ((state == mem_sys_pkg::COMPARE_RD) ||
                             (state == mem_sys_pkg::COMPARE_WR));

  req_capture capture (.clk, .arst_n, .addr, .data_in, .rd, .wr, .stall, .req_tag, .req_index,
    .req_offset, .req_wdata, .req_is_wr, .req_valid, .req_bad);

  cache_way way0 (.clk, .arst_n, .en(en0), .comp(way_comp), .write(way_write),
    .valid_in(way_valid_in), .tag_in(req_tag), .index(req_index), .word(way_word),
    .wdata(way_wdata), .hit(hit0), .valid(valid0), .dirty(dirty0), .tag_out(tag0),
    .rdata(rdata0));
  cache_way way1 (.clk, .arst_n, .en(en1), .comp(way_comp), .write(way_write),
    .valid_in(way_valid_in), .tag_in(req_tag), .index(req_index), .word(way_word),
    .wdata(way_wdata), .hit(hit1), .valid(valid1), .dirty(dirty1), .tag_out(tag1),
    .rdata(rdata1));

  cache_ctrl_fsm ctrl (.clk, .arst_n, .req_valid, .req_bad, .req_is_wr, .hit, .dirty_victim,
    .rvalid, .mem_stall, .state, .stall, .done, .err, .way_comp, .way_write, .way_valid_in,
    .word_sel, .mem_op, .mem_word);

  way_arbiter arb (.clk, .arst_n, .state, .req_index, .hit0, .hit1, .valid0, .valid1, .dirty0,
    .dirty1, .tag0, .tag1, .rdata0, .rdata1, .en0, .en1, .hit, .dirty_victim, .victim_tag,
    .line_data);

  four_bank_mem mem (.clk, .arst_n, .mem_op, .addr(mem_addr), .wdata(line_data),
    .rdata(mem_rdata), .rvalid, .mem_stall);

endmodule

// ==== req_capture.sv ====
// request input stage, latches an accepted request and flags illegal ones
`timescale 1ns/1ns
`include "mem_sys_defs.svh"

module req_capture (
  input  logic                clk,
  input  logic                arst_n,
  input  logic [`ADDR_W-1:0]  addr,
  input  logic [`DATA_W-1:0]  data_in,
  input  logic                rd,
  input  logic                wr,
  input  logic                stall,
  output logic [`TAG_W-1:0]   req_tag,
  output logic [`INDEX_W-1:0] req_index,
  output logic [`OFFS_W-1:0]  req_offset,
  output logic [`DATA_W-1:0]  req_wdata,
  output logic                req_is_wr,
  output logic                req_valid,
  output logic                req_bad
);

  logic accept;
  logic illegal;  // both strobes or odd address

  assign accept    = (rd || wr) && !stall;
  assign illegal   = (rd && wr) || addr[0];
  assign req_valid = accept && !illegal;
  assign req_bad   = accept && illegal;
  // fsm picks the compare state on the accepting edge
  assign req_is_wr = wr;

  always_ff @(posedge clk) begin
    if (req_valid) begin
      req_tag    <= addr[`ADDR_W-1:`ADDR_W-`TAG_W];
      req_index  <= addr[`OFFS_W+`INDEX_W-1:`OFFS_W];
      req_offset <= addr[`OFFS_W-1:0];
      req_wdata  <= data_in;
    end
  end

  a_valid_bad_excl: assert property (@(posedge clk) disable iff (!arst_n)
    !(req_valid && req_bad));

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the cached memory testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1
LOG=sim.log

if ! verilator --binary --timing --assert -Wno-fatal -f sim.f \
    --top-module tb_mem_system -o vsim; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/vsim > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ "$status" -ne 0 ]; then
  echo "simulator exited with status $status"
  exit 1
fi

if grep -qx "Simulation passed" "$LOG"; then
  exit 0
fi
echo "pass line not found in $LOG"
exit 1

// ==== sim.f ====
+incdir+.
mem_sys_pkg.sv
req_capture.sv
cache_way.sv
cache_ctrl_fsm.sv
way_arbiter.sv
four_bank_mem.sv
mem_system.sv
tb_mem_system.sv

// ==== tb_mem_system.sv ====
// self-checking testbench for the cached memory system, reference word model plus assertions
`timescale 1ns/1ns
`include "mem_sys_defs.svh"

module tb_mem_system;

  localparam int ANY   = 0;  // no hit or miss expectation
  localparam int HIT   = 1;
  localparam int MISS  = 2;
  localparam int LIMIT = 200;  // cycles allowed per wait

  logic               clk;
  logic               arst_n;
  logic [`ADDR_W-1:0] addr;
  logic [`DATA_W-1:0] data_in;
  logic               rd;
  logic               wr;
  logic [`DATA_W-1:0] data_out;
  logic               done;
  logic               stall;
  logic               cache_hit;
  logic               err;

  logic [`DATA_W-1:0] model [1 << (`ADDR_W-1)];  // one entry per word address
  int                 want;
  logic               acc;
  logic               acc_bad;
  logic               acc_ok;
  logic               pend;  // legal request outstanding
  logic               pend_rd;
  logic [`DATA_W-1:0] exp_data;

  mem_system DUT (.clk, .arst_n, .addr, .data_in, .rd, .wr, .data_out, .done, .stall,
    .cache_hit, .err);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  assign acc     = (rd || wr) && !stall;
  assign acc_bad = acc && ((rd && wr) || addr[0]);
  assign acc_ok  = acc && !acc_bad;

  // reference model, writes land at acceptance
  always @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < (1 << (`ADDR_W-1)); i++) begin
        model[i] <= '0;
      end
      pend     <= 1'b0;
      pend_rd  <= 1'b0;
      exp_data <= '0;
    end else if (acc_ok) begin
      pend     <= 1'b1;
      pend_rd  <= rd;
      exp_data <= model[addr[`ADDR_W-1:1]];
      if (wr) begin
        model[addr[`ADDR_W-1:1]] <= data_in;
      end
    end else if (done) begin
      pend <= 1'b0;
    end
  end

  a_read_data: assert property (@(posedge clk) disable iff (!arst_n)
    done && pend && pend_rd |-> data_out == exp_data)
    else abort_run($sformatf("Mismatch at %0t: read returned %h, model holds %h",
      $time, $sampled(data_out), $sampled(exp_data)));
  a_hit_or_miss: assert property (@(posedge clk) disable iff (!arst_n)
    acc_ok |=> (done && cache_hit) || (stall && !done && !cache_hit))
    else abort_run($sformatf("at %0t the cycle after acceptance was neither hit nor miss", $time));
  a_expect_hit: assert property (@(posedge clk) disable iff (!arst_n)
    acc_ok && want == HIT |=> done && cache_hit)
    else abort_run($sformatf("at %0t a request that should hit did not", $time));
  a_expect_miss: assert property (@(posedge clk) disable iff (!arst_n)
    acc_ok && want == MISS |=> stall && !done)
    else abort_run($sformatf("at %0t a request that should miss did not", $time));
  a_miss_end: assert property (@(posedge clk) disable iff (!arst_n)
    done && $past(stall) |-> !cache_hit)
    else abort_run($sformatf("at %0t cache_hit was high at the end of a miss", $time));
  a_bad_err: assert property (@(posedge clk) disable iff (!arst_n)
    acc_bad |=> err && !done)
    else abort_run($sformatf("at %0t an illegal request gave no clean err pulse", $time));
  a_err_owned: assert property (@(posedge clk) disable iff (!arst_n)
    err |-> $past(acc_bad))
    else abort_run($sformatf("at %0t err rose without an illegal request", $time));
  a_done_owned: assert property (@(posedge clk) disable iff (!arst_n)
    done |-> pend)
    else abort_run($sformatf("at %0t done pulsed with no request outstanding", $time));
  a_reset_quiet: assert property (@(posedge clk)
    $rose(arst_n) |-> !done && !stall && !cache_hit && !err &&
      DUT.state == mem_sys_pkg::IDLE)
    else abort_run("outputs were not quiet right after reset");

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1, "run stopped at first error");
  endtask

  function automatic logic [`ADDR_W-1:0] line_addr(input logic [`TAG_W-1:0] tag,
      input logic [`INDEX_W-1:0] index, input logic [`OFFS_W-2:0] word);
    return {tag, index, word, 1'b0};
  endfunction

  // drives on a falling edge, returns one falling edge after acceptance
  task automatic send_req(input logic do_rd, input logic do_wr, input logic [`ADDR_W-1:0] a,
      input logic [`DATA_W-1:0] d, input int kind);
    int waited;
    waited  = 0;
    addr    = a;
    data_in = d;
    rd      = do_rd;
    wr      = do_wr;
    want    = kind;
    while (stall) begin
      @(negedge clk);
      waited++;
      if (waited > LIMIT) abort_run("request was never accepted, stall stayed high");
    end
    @(negedge clk);
    rd   = 1'b0;
    wr   = 1'b0;
    want = ANY;
  endtask

  task automatic finish_req();
    int waited;
    waited = 0;
    while (!(done || err)) begin
      @(negedge clk);
      waited++;
      if (waited > LIMIT) abort_run("timed out waiting for done or err");
    end
  endtask

  task automatic read_word(input logic [`ADDR_W-1:0] a, input int kind);
    send_req(1'b1, 1'b0, a, '0, kind);
    finish_req();
  endtask

  task automatic write_word(input logic [`ADDR_W-1:0] a, input logic [`DATA_W-1:0] d,
      input int kind);
    send_req(1'b0, 1'b1, a, d, kind);
    finish_req();
  endtask

  initial begin
    logic [`ADDR_W-1:0] a;
    logic [`ADDR_W-1:0] b;
    logic [`ADDR_W-1:0] c;
    int                 waited;
    void'($urandom(32'h48c8_7690));
    arst_n  = 1'b0;
    addr    = '0;
    data_in = '0;
    rd      = 1'b0;
    wr      = 1'b0;
    want    = ANY;
    repeat (10) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    @(negedge clk);

    read_word(16'h1230, MISS);  // untouched, returns zero
    write_word(16'h0a48, 16'h5a3c, MISS);
    read_word(16'h0a48, HIT);

    // three tags on set 5
    a = line_addr(5'd1, 8'h05, 2'd2);
    b = line_addr(5'd2, 8'h05, 2'd2);
    c = line_addr(5'd3, 8'h05, 2'd2);
    write_word(a, 16'h1111, MISS);
    write_word(b, 16'h2222, MISS);
    read_word(a, HIT);
    write_word(c, 16'h3333, MISS);  // B is LRU and dirty
    read_word(a, HIT);
    read_word(b, MISS);             // back from memory after write-back

    for (int i = 0; i < 80; i++) begin
      c = line_addr(5'($urandom_range(3)), 8'($urandom_range(1)), 2'($urandom_range(3)));
      if ($urandom_range(1) == 1) write_word(c, 16'($urandom), ANY);
      else read_word(c, ANY);
    end

    // illegal requests leave memory alone
    send_req(1'b1, 1'b1, a, 16'hdead, ANY);
    finish_req();
    send_req(1'b1, 1'b0, a | 16'h1, '0, ANY);
    finish_req();
    send_req(1'b0, 1'b1, a | 16'h1, 16'hbeef, ANY);
    finish_req();
    read_word(a, ANY);

    // writes offered while stalled are dropped
    b = line_addr(5'd9, 8'h20, 2'd0);
    c = line_addr(5'd9, 8'h21, 2'd1);
    send_req(1'b0, 1'b1, b, 16'h1357, MISS);
    waited = 0;
    while (stall) begin
      addr    = c;
      data_in = 16'h7777;
      wr      = 1'b1;
      @(negedge clk);
      waited++;
      if (waited > LIMIT) abort_run("stall never dropped during the miss");
    end
    wr = 1'b0;
    finish_req();
    read_word(c, ANY);  // still zero
    read_word(b, HIT);

    $display("Simulation passed");
    $finish;
  end

endmodule

// ==== way_arbiter.sv ====
// merges the two ways, keeps per-set LRU, picks the victim and muxes data and tag
`timescale 1ns/1ns
`include "mem_sys_defs.svh"

module way_arbiter (
  input  logic                     clk,
  input  logic                     arst_n,
  input  mem_sys_pkg::ctrl_state_t state,
  input  logic [`INDEX_W-1:0]      req_index,
  input  logic                     hit0,
  input  logic                     hit1,
  input  logic                     valid0,
  input  logic                     valid1,
  input  logic                     dirty0,
  input  logic                     dirty1,
  input  logic [`TAG_W-1:0]        tag0,
  input  logic [`TAG_W-1:0]        tag1,
  input  logic [`DATA_W-1:0]       rdata0,
  input  logic [`DATA_W-1:0]       rdata1,
  output logic                     en0,
  output logic                     en1,
  output logic                     hit,
  output logic                     dirty_victim,
  output logic [`TAG_W-1:0]        victim_tag,
  output logic [`DATA_W-1:0]       line_data
);

  logic [(1 << `INDEX_W)-1:0] lru_q;  // most recently used way per set
  logic victim_q;
  logic victim_nxt;
  logic sel;      // 1 selects way 1
  logic first_cmp;
  logic cmp_st;   // both ways looked up
  logic fill_st;  // only the victim way is touched

  assign first_cmp = (state == mem_sys_pkg::COMPARE_RD) || (state == mem_sys_pkg::COMPARE_WR);
  assign cmp_st    = first_cmp || (state == mem_sys_pkg::RETRY);
  assign fill_st   = !cmp_st && (state != mem_sys_pkg::IDLE) &&
                     (state != mem_sys_pkg::ERR_STATE);

  // invalid way first, way 0 if both are empty
  assign victim_nxt = !valid0 ? 1'b0 : (!valid1 ? 1'b1 : !lru_q[req_index]);

  assign hit = hit0 || hit1;
  assign sel = cmp_st ? (hit ? hit1 : victim_nxt) : victim_q;
  assign en0 = cmp_st || (fill_st && !victim_q);
  assign en1 = cmp_st || (fill_st && victim_q);

  assign dirty_victim = sel ? (valid1 && dirty1) : (valid0 && dirty0);
  assign victim_tag   = sel ? tag1 : tag0;
  assign line_data    = sel ? rdata1 : rdata0;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      lru_q    <= '0;
      victim_q <= 1'b0;
    end else begin
      if (cmp_st && hit) begin
        lru_q[req_index] <= hit1;
      end
      if (first_cmp && !hit) begin
        victim_q <= victim_nxt;  // held for the whole miss
      end
    end
  end

endmodule
